// ==== source/mem_stage_pkg.sv ====
`default_nettype none

package mem_stage_pkg;

	typedef logic [63:0] xlen_t;
	typedef logic [63:0] addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [63:0] byte_mask_t; // one byte lane is all ones or all zeros

	// access-size codes, instruction bits 14:12
	localparam funct3_t f3_b  = 3'd0;
	localparam funct3_t f3_h  = 3'd1;
	localparam funct3_t f3_w  = 3'd2;
	localparam funct3_t f3_d  = 3'd3;
	localparam funct3_t f3_bu = 3'd4;
	localparam funct3_t f3_hu = 3'd5;
	localparam funct3_t f3_wu = 3'd6;

	localparam addr_t default_ram_base = 64'h8000_0000;
	localparam int    word_off_bits    = 3; // byte offset bits in a 64-bit word

	// byte offset rounded down to the access size, codes 0..3 give b/h/w/d
	function automatic logic [word_off_bits-1:0] lane_offset(
		input addr_t   rel_addr,
		input funct3_t f3
	);
		logic [word_off_bits-1:0] align;
		begin
			align = {word_off_bits{1'b1}} << f3[1:0];
			return rel_addr[word_off_bits-1:0] & align;
		end
	endfunction

endpackage

`default_nettype wire

// ==== source/mem_access_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_access_if;
	import mem_stage_pkg::*;

	addr_t   addr;       // alu result
	funct3_t funct3;
	xlen_t   store_data;
	logic    is_store;
	logic    is_load;

	modport store_side (
		input addr,
		input funct3,
		input store_data,
		input is_store
	);

	modport load_side (
		input addr,
		input funct3,
		input is_load
	);

	modport ram_side (
		input addr
	);

endinterface

`default_nettype wire

// ==== source/store_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_align #(
	parameter mem_stage_pkg::addr_t ram_base = mem_stage_pkg::default_ram_base
) (
	mem_access_if.store_side           acc,
	output mem_stage_pkg::byte_mask_t  wmask,
	output mem_stage_pkg::xlen_t       wdata
);
	import mem_stage_pkg::*;

	addr_t                    rel_addr;
	logic [word_off_bits-1:0] off;
	logic [7:0]               size_lanes;
	logic [7:0]               lanes;

	always_comb begin
		rel_addr   = acc.addr - ram_base;
		off        = lane_offset(rel_addr, acc.funct3);
		size_lanes = 8'h00;
		if (acc.is_store) begin
			case (acc.funct3)
				f3_b:    size_lanes = 8'h01; // sb
				f3_h:    size_lanes = 8'h03; // sh
				f3_w:    size_lanes = 8'h0f; // sw
				f3_d:    size_lanes = 8'hff; // sd
				default: size_lanes = 8'h00;
			endcase
		end
		lanes = size_lanes << off;
	end

	always_comb begin
		for (int i = 0; i < 8; i++) begin
			wmask[8*i +: 8] = {8{lanes[i]}}; // byte lane to bit mask
		end
	end

	assign wdata = acc.store_data << {off, 3'b000}; // move into target lanes

	// the size decode only knows the four store widths
	always_comb begin
		if (acc.is_store) begin
			assert #0 (acc.funct3 <= f3_d)
				else $error("store with load-only size code %0d", acc.funct3);
		end
	end

endmodule

`default_nettype wire

// ==== source/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
	parameter mem_stage_pkg::addr_t ram_base       = mem_stage_pkg::default_ram_base,
	parameter int                   ram_words_log2 = 10
) (
	input  wire                             clk,
	mem_access_if.ram_side                  acc,
	input  wire                             fire,
	input  wire mem_stage_pkg::byte_mask_t  wmask,
	input  wire mem_stage_pkg::xlen_t       wdata,
	output mem_stage_pkg::xlen_t            rdata
);
	import mem_stage_pkg::*;

	localparam addr_t ram_bytes = addr_t'(1) << (ram_words_log2 + word_off_bits);

	xlen_t                     mem [2**ram_words_log2];
	addr_t                     rel_addr;
	logic [ram_words_log2-1:0] idx;

	assign rel_addr = acc.addr - ram_base;
	assign idx      = rel_addr[word_off_bits +: ram_words_log2];
	assign rdata    = mem[idx]; // async read, old contents on the write edge

	always_ff @(posedge clk) begin
		if (fire) begin
			mem[idx] <= (mem[idx] & ~wmask) | (wdata & wmask);
		end
	end

	// a committed store must land inside the window, no silent wrap
	assert property (@(posedge clk) (fire && wmask != '0) |-> (rel_addr < ram_bytes))
		else $error("store outside data memory window, addr %h", acc.addr);

endmodule

`default_nettype wire

// ==== source/load_extract.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_extract #(
	parameter mem_stage_pkg::addr_t ram_base = mem_stage_pkg::default_ram_base
) (
	mem_access_if.load_side           acc,
	input  wire mem_stage_pkg::xlen_t rdata,
	output mem_stage_pkg::xlen_t      load_value
);
	import mem_stage_pkg::*;

	addr_t                    rel_addr;
	logic [word_off_bits-1:0] off;
	xlen_t                    field;

	always_comb begin
		rel_addr = acc.addr - ram_base;
		off      = lane_offset(rel_addr, acc.funct3);
		field    = rdata >> {off, 3'b000}; // addressed field down to bit 0
	end

	always_comb begin
		load_value = '0;
		if (acc.is_load) begin
			case (acc.funct3)
				f3_b: begin
					load_value = {{56{field[7]}}, field[7:0]};
				end
				f3_h: begin
					load_value = {{48{field[15]}}, field[15:0]};
				end
				f3_w: begin
					load_value = {{32{field[31]}}, field[31:0]};
				end
				f3_d: begin
					load_value = field;
				end
				f3_bu: begin
					load_value = {56'h0, field[7:0]};
				end
				f3_hu: begin
					load_value = {48'h0, field[15:0]};
				end
				f3_wu: begin
					load_value = {32'h0, field[31:0]};
				end
				default: begin
					load_value = '0; // no 8-byte unsigned load
				end
			endcase
		end
	end

	// execute stage never hands over code 7 as a load
	always_comb begin
		if (acc.is_load) begin
			assert #0 (acc.funct3 != 3'd7)
				else $error("load with reserved size code 7");
		end
	end

endmodule

`default_nettype wire

// ==== source/wb_stage_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_stage_reg (
	input  wire                            clk,
	input  wire                            reset,
	input  wire                            valid_in,
	input  wire                            ready_out,
	output logic                           ready_in,
	output logic                           fire,
	input  wire                            is_load,
	input  wire mem_stage_pkg::xlen_t      alu_result,
	input  wire mem_stage_pkg::xlen_t      load_value,
	input  wire mem_stage_pkg::addr_t      pc_in,
	input  wire mem_stage_pkg::inst_t      ins_in,
	input  wire                            reg_w_en_in,
	input  wire mem_stage_pkg::reg_idx_t   rdest_in,
	output logic                           valid_out,
	output mem_stage_pkg::addr_t           pc_out,
	output mem_stage_pkg::inst_t           ins_out,
	output logic                           reg_w_en_out,
	output mem_stage_pkg::reg_idx_t        rdest_out,
	output mem_stage_pkg::xlen_t           wb_data_out,
	output logic                           reg_w_en_fwd,
	output mem_stage_pkg::reg_idx_t        rdest_fwd,
	output mem_stage_pkg::xlen_t           wb_data_fwd
);
	import mem_stage_pkg::*;

	xlen_t wb_data;

	assign ready_in = ready_out;             // no buffering in this stage
	assign fire     = valid_in & ready_out;

	assign wb_data      = is_load ? load_value : alu_result;
	assign wb_data_fwd  = wb_data;           // bypass to decode, same cycle
	assign reg_w_en_fwd = reg_w_en_in;
	assign rdest_fwd    = rdest_in;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out    <= 1'b0;
			pc_out       <= pc_in;
			ins_out      <= '0;
			reg_w_en_out <= 1'b0;
			rdest_out    <= '0;
			wb_data_out  <= '0;
		end else if (ready_out) begin
			valid_out <= valid_in;
			if (valid_in) begin
				pc_out       <= pc_in;
				ins_out      <= ins_in;
				reg_w_en_out <= reg_w_en_in;
				rdest_out    <= rdest_in;
				wb_data_out  <= wb_data;
			end
		end
	end

	// write-back stage must see an empty slot right out of reset
	assert property (@(posedge clk) reset |=> !valid_out)
		else $error("valid_out set in the cycle after reset");

endmodule

`default_nettype wire

// ==== source/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
	parameter mem_stage_pkg::addr_t ram_base       = mem_stage_pkg::default_ram_base,
	parameter int                   ram_words_log2 = 10
) (
	input  wire                            clk,
	input  wire                            reset,
	input  wire                            valid_in,
	input  wire                            ready_out,
	output logic                           ready_in,
	input  wire mem_stage_pkg::addr_t      pc_in,
	input  wire mem_stage_pkg::inst_t      ins_in,
	input  wire mem_stage_pkg::xlen_t      alu_result,
	input  wire mem_stage_pkg::xlen_t      store_data,
	input  wire                            mem_write,
	input  wire                            is_load,
	input  wire                            reg_w_en_in,
	input  wire mem_stage_pkg::reg_idx_t   rdest_in,
	output logic                           valid_out,
	output mem_stage_pkg::addr_t           pc_out,
	output mem_stage_pkg::inst_t           ins_out,
	output logic                           reg_w_en_out,
	output mem_stage_pkg::reg_idx_t        rdest_out,
	output mem_stage_pkg::xlen_t           wb_data_out,
	output logic                           reg_w_en_fwd,
	output mem_stage_pkg::reg_idx_t        rdest_fwd,
	output mem_stage_pkg::xlen_t           wb_data_fwd
);
	import mem_stage_pkg::*;

	byte_mask_t wmask;
	xlen_t      wdata;
	xlen_t      rdata;
	xlen_t      load_value;
	logic       fire;

	mem_access_if acc ();

	assign acc.addr       = alu_result;
	assign acc.funct3     = ins_in[14:12];
	assign acc.store_data = store_data;
	assign acc.is_store   = mem_write;
	assign acc.is_load    = is_load;

	store_align #(
		.ram_base (ram_base)
	) store_align_inst (
		.acc   (acc.store_side),
		.wmask (wmask),
		.wdata (wdata)
	);

	data_ram #(
		.ram_base       (ram_base),
		.ram_words_log2 (ram_words_log2)
	) data_ram_inst (
		.clk   (clk),
		.acc   (acc.ram_side),
		.fire  (fire),         // store commits only on a handshake
		.wmask (wmask),
		.wdata (wdata),
		.rdata (rdata)
	);

	load_extract #(
		.ram_base (ram_base)
	) load_extract_inst (
		.acc        (acc.load_side),
		.rdata      (rdata),
		.load_value (load_value)
	);

	wb_stage_reg wb_stage_reg_inst (
		.clk          (clk),
		.reset        (reset),
		.valid_in     (valid_in),
		.ready_out    (ready_out),
		.ready_in     (ready_in),
		.fire         (fire),
		.is_load      (is_load),
		.alu_result   (alu_result),
		.load_value   (load_value),
		.pc_in        (pc_in),
		.ins_in       (ins_in),
		.reg_w_en_in  (reg_w_en_in),
		.rdest_in     (rdest_in),
		.valid_out    (valid_out),
		.pc_out       (pc_out),
		.ins_out      (ins_out),
		.reg_w_en_out (reg_w_en_out),
		.rdest_out    (rdest_out),
		.wb_data_out  (wb_data_out),
		.reg_w_en_fwd (reg_w_en_fwd),
		.rdest_fwd    (rdest_fwd),
		.wb_data_fwd  (wb_data_fwd)
	);

endmodule

`default_nettype wire

// ==== tb/mem_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage_tb;

	localparam logic [63:0] ram_base       = 64'h8000_0000;
	localparam int          ram_words_log2 = 10;
	localparam int          num_words      = 32; // words actually touched by loads
	localparam int          reset_cycles   = 3;
	localparam int          partial_count  = 150;
	localparam int          ext_words      = 12;
	localparam int          alu_count      = 80;
	localparam int          bp_rounds      = 40;
	localparam int          stall_len      = 3;
	localparam int          tail_cycles    = 3;
	localparam int          phase_cycles   = reset_cycles + 2 * num_words + 2 * partial_count
		+ 29 * ext_words + alu_count + (2 + stall_len) * bp_rounds + tail_cycles;
	localparam int          cycle_limit    = 2 * phase_cycles;

	logic        clk = 1'b0;
	logic        reset;
	logic        valid_in;
	logic        ready_out;
	logic        ready_in;
	logic [63:0] pc_in;
	logic [31:0] ins_in;
	logic [63:0] alu_result;
	logic [63:0] store_data;
	logic        mem_write;
	logic        is_load;
	logic        reg_w_en_in;
	logic [4:0]  rdest_in;
	logic        valid_out;
	logic [63:0] pc_out;
	logic [31:0] ins_out;
	logic        reg_w_en_out;
	logic [4:0]  rdest_out;
	logic [63:0] wb_data_out;
	logic        reg_w_en_fwd;
	logic [4:0]  rdest_fwd;
	logic [63:0] wb_data_fwd;

	logic [63:0] ref_mem [0:2**ram_words_log2-1]; // mirror of committed stores
	logic [63:0] lcg_state   = 64'd23;
	int          error_count = 0;
	int          fire_count  = 0;
	int          cycle_count = 0;
	string       test_name   = "reset";

	logic                      reset_seen = 1'b0;
	logic                      reset_q    = 1'b0;
	logic [63:0]               rel;
	logic [ram_words_log2-1:0] cur_idx;
	int                        cur_off;
	logic [63:0]               exp_now;
	logic                      exp_valid;
	logic [63:0]               exp_pc;
	logic [31:0]               exp_ins;
	logic                      exp_wen;
	logic [4:0]                exp_rdest;
	logic [63:0]               exp_wb;
	wire                       in_reset_window = reset_seen && (reset || reset_q);

	mem_stage #(
		.ram_base       (ram_base),
		.ram_words_log2 (ram_words_log2)
	) mem_stage_inst (
		.clk          (clk),
		.reset        (reset),
		.valid_in     (valid_in),
		.ready_out    (ready_out),
		.ready_in     (ready_in),
		.pc_in        (pc_in),
		.ins_in       (ins_in),
		.alu_result   (alu_result),
		.store_data   (store_data),
		.mem_write    (mem_write),
		.is_load      (is_load),
		.reg_w_en_in  (reg_w_en_in),
		.rdest_in     (rdest_in),
		.valid_out    (valid_out),
		.pc_out       (pc_out),
		.ins_out      (ins_out),
		.reg_w_en_out (reg_w_en_out),
		.rdest_out    (rdest_out),
		.wb_data_out  (wb_data_out),
		.reg_w_en_fwd (reg_w_en_fwd),
		.rdest_fwd    (rdest_fwd),
		.wb_data_fwd  (wb_data_fwd)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] rand32();
		lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
		return lcg_state[63:32]; // high half since low lcg bits are weak
	endfunction

	function automatic logic [63:0] rand64();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = rand32();
		lo = rand32();
		return {hi, lo};
	endfunction

	function automatic logic [63:0] word_addr(input int w, input int off);
		return ram_base + 64'(w) * 64'd8 + 64'(off);
	endfunction

	// offset inside the word rounded down to the access size
	function automatic int round_off(input logic [63:0] rel_addr, input logic [2:0] f3);
		int size;
		int o;
		size = 1 << f3[1:0];
		o    = int'(rel_addr[2:0]);
		return o - (o % size);
	endfunction

	function automatic logic [63:0] merge_store(input logic [63:0] old, input logic [63:0] data,
		input logic [2:0] f3, input int off);
		logic [63:0] res;
		int          size;
		int          b;
		res  = old;
		size = 1 << f3[1:0];
		for (b = 0; b < size; b++) begin
			res[8*(off+b) +: 8] = data[8*b +: 8];
		end
		return res;
	endfunction

	function automatic logic [63:0] load_ref(input logic [63:0] word, input logic [2:0] f3,
		input int off);
		logic [63:0] field;
		int          size;
		int          b;
		field = '0;
		size  = 1 << f3[1:0];
		for (b = 0; b < size; b++) begin
			field[8*b +: 8] = word[8*(off+b) +: 8];
		end
		if (!f3[2] && size < 8 && field[8*size-1]) begin
			for (b = size; b < 8; b++) begin
				field[8*b +: 8] = 8'hff; // sign fill
			end
		end
		return field;
	endfunction

	task automatic report_mismatch(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		error_count++;
		$display("ERROR: %s: %s expected %h actual %h", test_name, what, expected, actual);
	endtask

	task automatic report_failure(input string msg);
		error_count++;
		$display("failure in %s: %s", test_name, msg);
	endtask

	// expected write-back value from the inputs now on the port
	always_comb begin
		rel     = alu_result - ram_base;
		cur_idx = rel[3 +: ram_words_log2];
		cur_off = round_off(rel, ins_in[14:12]);
		exp_now = is_load ? load_ref(ref_mem[cur_idx], ins_in[14:12], cur_off) : alu_result;
	end

	always @(posedge clk) begin
		reset_q <= reset;
		if (reset) begin
			reset_seen <= 1'b1;
			exp_valid  <= 1'b0;
		end else begin
			if (ready_out) begin
				exp_valid <= valid_in;
			end
			if (valid_in && ready_out) begin
				exp_pc     <= pc_in;
				exp_ins    <= ins_in;
				exp_wen    <= reg_w_en_in;
				exp_rdest  <= rdest_in;
				exp_wb     <= exp_now;
				fire_count <= fire_count + 1;
				if (mem_write) begin
					ref_mem[cur_idx] <= merge_store(ref_mem[cur_idx], store_data,
						ins_in[14:12], cur_off);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("mem_stage_tb: %0d transfers, %0d errors", fire_count, error_count);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	reset_check: assert property (@(posedge clk) in_reset_window
		|-> (!valid_out && !reg_w_en_out && wb_data_out == '0))
		else report_failure("outputs not cleared through reset");

	ready_check: assert property (@(posedge clk) ready_in == ready_out)
		else report_mismatch("ready_in", $sampled(ready_out), $sampled(ready_in));

	valid_check: assert property (@(posedge clk) disable iff (reset)
		ready_out |=> valid_out == exp_valid)
		else report_mismatch("valid_out", $sampled(exp_valid), $sampled(valid_out));

	wb_check: assert property (@(posedge clk) disable iff (reset)
		(valid_in && ready_out) |=> wb_data_out == exp_wb)
		else report_mismatch("wb_data_out", $sampled(exp_wb), $sampled(wb_data_out));

	pc_check: assert property (@(posedge clk) disable iff (reset)
		(valid_in && ready_out) |=> pc_out == exp_pc)
		else report_mismatch("pc_out", $sampled(exp_pc), $sampled(pc_out));

	ins_check: assert property (@(posedge clk) disable iff (reset)
		(valid_in && ready_out) |=> ins_out == exp_ins)
		else report_mismatch("ins_out", $sampled(exp_ins), $sampled(ins_out));

	wen_check: assert property (@(posedge clk) disable iff (reset)
		(valid_in && ready_out) |=> reg_w_en_out == exp_wen)
		else report_mismatch("reg_w_en_out", $sampled(exp_wen), $sampled(reg_w_en_out));

	rdest_check: assert property (@(posedge clk) disable iff (reset)
		(valid_in && ready_out) |=> rdest_out == exp_rdest)
		else report_mismatch("rdest_out", $sampled(exp_rdest), $sampled(rdest_out));

	fwd_data_check: assert property (@(posedge clk) disable iff (reset)
		wb_data_fwd == exp_now)
		else report_mismatch("wb_data_fwd", $sampled(exp_now), $sampled(wb_data_fwd));

	fwd_wen_check: assert property (@(posedge clk) disable iff (reset)
		reg_w_en_fwd == reg_w_en_in)
		else report_mismatch("reg_w_en_fwd", $sampled(reg_w_en_in),
			$sampled(reg_w_en_fwd));

	fwd_rdest_check: assert property (@(posedge clk) disable iff (reset)
		rdest_fwd == rdest_in)
		else report_mismatch("rdest_fwd", $sampled(rdest_in), $sampled(rdest_fwd));

	hold_check: assert property (@(posedge clk) disable iff (reset)
		!ready_out |=> ($stable(valid_out) && $stable(pc_out) && $stable(ins_out)
		&& $stable(reg_w_en_out) && $stable(rdest_out) && $stable(wb_data_out)))
		else report_failure("registered outputs changed while ready_out was low");

	task automatic present(input logic store, input logic load, input logic [2:0] f3,
		input logic [63:0] addr, input logic [63:0] data);
		logic [31:0] word;
		logic [63:0] pc;
		word        = rand32();
		pc          = rand64();
		valid_in    = 1'b1;
		mem_write   = store;
		is_load     = load;
		alu_result  = addr;
		store_data  = data;
		ins_in      = {word[31:15], f3, word[11:0]};
		pc_in       = {pc[63:2], 2'b00};
		rdest_in    = word[11:7]; // rd field of the instruction
		reg_w_en_in = load | (~store & word[6]);
	endtask

	task automatic issue(input logic store, input logic load, input logic [2:0] f3,
		input logic [63:0] addr, input logic [63:0] data);
		present(store, load, f3, addr, data);
		@(posedge clk);
		while (!ready_in) begin
			@(posedge clk);
		end
		#1;
	endtask

	task automatic idle(input int n);
		valid_in  = 1'b0;
		mem_write = 1'b0;
		is_load   = 1'b0;
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic round_trip_test();
		int w;
		test_name = "sd_ld_round_trip";
		for (w = 0; w < num_words; w++) begin
			issue(1'b1, 1'b0, 3'd3, word_addr(w, 0), rand64()); // also fills the window
			issue(1'b0, 1'b1, 3'd3, word_addr(w, 0), 64'd0);
		end
	endtask

	task automatic partial_store_test();
		int          i;
		int          w;
		logic [2:0]  f3;
		test_name = "partial_store";
		for (i = 0; i < partial_count; i++) begin
			w  = rand32() % num_words;
			f3 = 3'(rand32() % 3);
			issue(1'b1, 1'b0, f3, word_addr(w, rand32() % 8), rand64());
			issue(1'b0, 1'b1, 3'd3, word_addr(w, 0), 64'd0);
		end
	endtask

	task automatic load_extension_test();
		int i;
		int w;
		int c;
		int o;
		int size;
		test_name = "load_extension";
		for (i = 0; i < ext_words; i++) begin
			w = rand32() % num_words;
			issue(1'b1, 1'b0, 3'd3, word_addr(w, 0), rand64());
			for (c = 0; c < 7; c++) begin
				if (c != 3) begin
					size = 1 << (c & 3);
					for (o = 0; o < 8; o += size) begin
						// low address bits inside the field get rounded away
						issue(1'b0, 1'b1, 3'(c), word_addr(w, o + rand32() % size), 64'd0);
					end
				end
			end
		end
	endtask

	task automatic forwarding_test();
		int i;
		test_name = "alu_forwarding";
		for (i = 0; i < alu_count; i++) begin
			if (rand32() % 5 == 0) begin
				idle(1);
			end else begin
				issue(1'b0, 1'b0, 3'(rand32()), rand64(), rand64());
			end
		end
	endtask

	task automatic back_pressure_test();
		int          i;
		int          w;
		logic [63:0] a;
		test_name = "back_pressure";
		for (i = 0; i < bp_rounds; i++) begin
			w = rand32() % num_words;
			a = word_addr(w, 0);
			issue(1'b0, 1'b1, 3'd3, a, 64'd0);
			ready_out = 1'b0;
			present(1'b1, 1'b0, 3'd3, a, rand64()); // stalled store must not commit
			repeat (stall_len) @(posedge clk);
			#1;
			ready_out = 1'b1;
			issue(1'b0, 1'b1, 3'd3, a, 64'd0);
		end
	endtask

	initial begin
		reset       = 1'b1;
		valid_in    = 1'b0;
		ready_out   = 1'b1;
		pc_in       = '0;
		ins_in      = '0;
		alu_result  = '0;
		store_data  = '0;
		mem_write   = 1'b0;
		is_load     = 1'b0;
		reg_w_en_in = 1'b0;
		rdest_in    = '0;
		repeat (reset_cycles) @(posedge clk);
		#1;
		reset = 1'b0;
		idle(1);
		round_trip_test();
		partial_store_test();
		load_extension_test();
		forwarding_test();
		back_pressure_test();
		idle(tail_cycles - 1);
		$display("mem_stage_tb: %0d transfers, %0d errors", fire_count, error_count);
		if (error_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
source/mem_stage_pkg.sv
source/mem_access_if.sv
source/store_align.sv
source/data_ram.sv
source/load_extract.sv
source/wb_stage_reg.sv
source/mem_stage.sv
tb/mem_stage_tb.sv
